/* logic/lz77_pkg.sv */
//----------------------------------------------------------------------
// shared constants and token types for the lz77 compressor
// DST_WD, LEN_WD and the token payload width all follow WIN_SIZE and
// MAX_LEN, so a change there changes the token port width
// MAX_LEN is also the lookahead depth of the window
//----------------------------------------------------------------------

package lz77_pkg;

  localparam int WIN_SIZE = 16;
  localparam int MAX_LEN  = 8;
  localparam int BYTE_WD  = 8;
  localparam int CNT_WD   = 16;

  // distance 1..WIN_SIZE, length 0..MAX_LEN
  localparam int DST_WD = $clog2(WIN_SIZE + 1);
  localparam int LEN_WD = $clog2(MAX_LEN + 1);

  // one spare bit keeps a pad field in both views
  localparam int MAT_WD  = LEN_WD + DST_WD;
  localparam int PAY_WD  = ((MAT_WD > BYTE_WD) ? MAT_WD : BYTE_WD) + 1;
  localparam int LIT_PAD = PAY_WD - BYTE_WD;
  localparam int MAT_PAD = PAY_WD - MAT_WD;

  typedef logic [BYTE_WD-1:0] byte_t;
  typedef logic [LEN_WD-1:0]  len_t;
  typedef logic [DST_WD-1:0]  dst_t;
  typedef logic [CNT_WD-1:0]  cnt_t;

  // token payload, literal byte or (length, distance) pair
  typedef union packed {
    struct packed {
      logic [LIT_PAD-1:0] pad;
      byte_t              dat;
    } lit;
    struct packed {
      logic [MAT_PAD-1:0] pad;
      len_t               len;
      dst_t               dst;
    } mat;
  } tok_payload_u;

endpackage

/* logic/lz77_window.sv */
//----------------------------------------------------------------------
// history and lookahead byte store
// one shift register in stream order, history then lookahead
// an advance moves up to MAX_LEN bytes in one cycle
// bytes not valid read as zero once clr_i has been seen
//----------------------------------------------------------------------

`timescale 1ns/1ps

module lz77_window (
  input  logic                                     clk,
  input  logic                                     rstn,
  input  logic                                     clr_i,
  input  logic                                     fill_i,
  input  logic                                     adv_i,
  input  lz77_pkg::byte_t                          fill_dat_i,
  input  lz77_pkg::len_t                           adv_len_i,
  output lz77_pkg::byte_t [lz77_pkg::WIN_SIZE-1:0] hist_o,
  output lz77_pkg::byte_t [lz77_pkg::MAX_LEN-1:0]  look_o,
  output lz77_pkg::dst_t                           hist_cnt_o,
  output lz77_pkg::len_t                           look_cnt_o
);

  localparam int WIN = lz77_pkg::WIN_SIZE;
  localparam int LA  = lz77_pkg::MAX_LEN;
  localparam int TOT = WIN + LA;

  // [0] oldest history, [WIN-1] newest history, [WIN] lookahead head
  lz77_pkg::byte_t [TOT-1:0]     store_r;
  lz77_pkg::byte_t [TOT-1:0]     store_nxt;
  lz77_pkg::dst_t                hist_cnt_r;
  lz77_pkg::len_t                look_cnt_r;
  lz77_pkg::len_t                step;
  logic [lz77_pkg::DST_WD:0]     hist_sum;

  always_comb begin
    step      = adv_i ? adv_len_i : '0;
    hist_sum  = {1'b0, hist_cnt_r} + step;
    // zeros enter at the lookahead tail
    store_nxt = store_r >> (step * lz77_pkg::BYTE_WD);
    if (fill_i) begin
      store_nxt[WIN + int'(look_cnt_r) - int'(step)] = fill_dat_i;
    end
  end

  always_ff @(posedge clk) begin
    if (clr_i) begin
      store_r <= '0;
    end else if (fill_i || adv_i) begin
      store_r <= store_nxt;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      hist_cnt_r <= '0;
      look_cnt_r <= '0;
    end else if (clr_i) begin
      hist_cnt_r <= '0;
      look_cnt_r <= '0;
    end else begin
      // history saturates, oldest bytes fall off
      if (adv_i) begin
        hist_cnt_r <= (hist_sum > WIN) ? lz77_pkg::dst_t'(WIN)
                                       : hist_sum[lz77_pkg::DST_WD-1:0];
      end
      look_cnt_r <= look_cnt_r + lz77_pkg::len_t'(fill_i) - step;
    end
  end

  //--------------------------------------------------------------------
  // output views
  //--------------------------------------------------------------------
  for (genvar d = 0; d < WIN; d++) begin : g_hist
    assign hist_o[d] = store_r[WIN-1-d];
  end

  for (genvar k = 0; k < LA; k++) begin : g_look
    assign look_o[k] = store_r[WIN+k];
  end

  assign hist_cnt_o = hist_cnt_r;
  assign look_cnt_o = look_cnt_r;

  a_no_fill_full: assert property (@(posedge clk) disable iff (!rstn)
    fill_i |-> (look_cnt_r < LA))
    else $error("fill into a full lookahead");

endmodule

/* logic/lz77_match.sv */
//----------------------------------------------------------------------
// longest match search, one lookahead byte per cycle
// one mask bit per distance, bit j stands for distance j+1
// look_cnt_i already carries the bytes-left cap of the job
// inputs must hold steady from go_i until done_o
//----------------------------------------------------------------------

`timescale 1ns/1ps

module lz77_match #(
  parameter int MIN_LEN = 3
) (
  input  logic                                     clk,
  input  logic                                     rstn,
  input  logic                                     go_i,
  input  lz77_pkg::byte_t [lz77_pkg::WIN_SIZE-1:0] hist_i,
  input  lz77_pkg::byte_t [lz77_pkg::MAX_LEN-1:0]  look_i,
  input  lz77_pkg::dst_t                           hist_cnt_i,
  input  lz77_pkg::len_t                           look_cnt_i,
  output logic                                     done_o,
  output logic                                     lit_o,
  output lz77_pkg::len_t                           len_o,
  output lz77_pkg::tok_payload_u                   pay_o
);

  localparam int WIN = lz77_pkg::WIN_SIZE;
  localparam int LA  = lz77_pkg::MAX_LEN;

  logic                   busy_r;
  logic [WIN-1:0]         mask_r;
  logic [WIN-1:0]         mask_cur;
  logic [WIN-1:0]         mask_nxt;
  lz77_pkg::len_t         k_r;
  lz77_pkg::len_t         k_cur;
  lz77_pkg::len_t         best_len_r;
  lz77_pkg::len_t         best_len_cur;
  lz77_pkg::len_t         fin_len;
  lz77_pkg::dst_t         best_dst_r;
  lz77_pkg::dst_t         best_dst_cur;
  lz77_pkg::dst_t         fin_dst;
  lz77_pkg::dst_t         pick_dst;
  lz77_pkg::byte_t        look_byte;
  logic                   step_en;
  logic                   finish;
  logic                   lit_nxt;
  lz77_pkg::tok_payload_u pay_nxt;

  //--------------------------------------------------------------------
  // one search step, the first one runs in the go_i cycle
  //--------------------------------------------------------------------
  always_comb begin
    mask_cur     = mask_r;
    k_cur        = k_r;
    best_len_cur = best_len_r;
    best_dst_cur = best_dst_r;
    if (go_i) begin
      for (int j = 0; j < WIN; j++) begin
        mask_cur[j] = (j < int'(hist_cnt_i));
      end
      k_cur        = '0;
      best_len_cur = '0;
      best_dst_cur = '0;
    end
    look_byte = look_i[k_cur];

    // source byte for distance j+1 at step k sits at hist index j-k
    for (int j = 0; j < WIN; j++) begin
      mask_nxt[j] = mask_cur[j] && (int'(k_cur) <= j) && (k_cur < look_cnt_i) &&
                    (int'(k_cur) < LA) &&
                    (hist_i[(j >= int'(k_cur)) ? j - int'(k_cur) : 0] == look_byte);
    end

    // lowest surviving index gives the smallest distance
    pick_dst = '0;
    for (int j = WIN - 1; j >= 0; j--) begin
      if (mask_nxt[j]) pick_dst = lz77_pkg::dst_t'(j + 1);
    end

    if (mask_nxt != '0) begin
      fin_len = k_cur + 1'b1;
      fin_dst = pick_dst;
    end else begin
      fin_len = best_len_cur;
      fin_dst = best_dst_cur;
    end

    step_en = go_i || busy_r;
    finish  = step_en && ((mask_nxt == '0) || ((k_cur + 1'b1) >= look_cnt_i));
    lit_nxt = (fin_len < MIN_LEN);

    pay_nxt = '0;
    if (lit_nxt) begin
      pay_nxt.lit.dat = look_i[0];
    end else begin
      pay_nxt.mat.len = fin_len;
      pay_nxt.mat.dst = fin_dst;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy_r <= 1'b0;
      done_o <= 1'b0;
      mask_r <= '0;
      k_r    <= '0;
    end else begin
      done_o <= finish;
      if (step_en) begin
        busy_r <= !finish;
        mask_r <= mask_nxt;
        k_r    <= finish ? '0 : k_cur + 1'b1;
      end
    end
  end

  // running best and the held result
  always_ff @(posedge clk) begin
    if (step_en) begin
      best_len_r <= fin_len;
      best_dst_r <= fin_dst;
    end
    if (finish) begin
      lit_o <= lit_nxt;
      len_o <= lit_nxt ? lz77_pkg::len_t'(1) : fin_len;
      pay_o <= pay_nxt;
    end
  end

  a_len_le_dst: assert property (@(posedge clk) disable iff (!rstn)
    (done_o && !lit_o) |-> (pay_o.mat.len <= pay_o.mat.dst))
    else $error("match length above its distance");

endmodule

/* logic/lz77_ctrl.sv */
//----------------------------------------------------------------------
// job control, input fetch and token output
// at most one read in flight, the byte is expected one cycle after rd_o
// window counts lag fill, adv and clr by one cycle, so no decision is
// taken in a cycle where one of them is still settling
//----------------------------------------------------------------------

`timescale 1ns/1ps

module lz77_ctrl (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   start_i,
  input  lz77_pkg::cnt_t         len_i,
  input  lz77_pkg::len_t         look_cnt_i,
  input  logic                   srch_done_i,
  input  logic                   srch_lit_i,
  input  lz77_pkg::len_t         srch_len_i,
  input  lz77_pkg::tok_payload_u srch_pay_i,
  output logic                   rd_o,
  output logic                   fill_o,
  output logic                   clr_o,
  output logic                   adv_o,
  output logic                   srch_go_o,
  output lz77_pkg::len_t         adv_len_o,
  output logic                   tok_val_o,
  output logic                   tok_lit_o,
  output logic                   tok_lst_o,
  output logic                   done_o,
  output lz77_pkg::tok_payload_u tok_pay_o
);

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_FILL   = 2'd1;
  localparam logic [1:0] ST_SEARCH = 2'd2;

  logic [1:0]     state_r;
  logic [1:0]     state_nxt;
  lz77_pkg::cnt_t rd_left_r;
  lz77_pkg::cnt_t con_left_r;
  lz77_pkg::len_t want;
  lz77_pkg::len_t avail;
  logic           settle;
  logic           start_ok;
  logic           rd_req;
  logic           tok_take;
  logic           last_tok;

  //--------------------------------------------------------------------
  // fetch and search decisions
  //--------------------------------------------------------------------
  always_comb begin
    want = (con_left_r > lz77_pkg::MAX_LEN) ? lz77_pkg::len_t'(lz77_pkg::MAX_LEN)
                                             : con_left_r[lz77_pkg::LEN_WD-1:0];
    // bytes present plus the ones on their way
    avail     = look_cnt_i + lz77_pkg::len_t'(rd_o) + lz77_pkg::len_t'(fill_o);
    settle    = clr_o || adv_o;
    start_ok  = (state_r == ST_IDLE) && start_i && (len_i != '0);
    rd_req    = (state_r == ST_FILL) && !settle && !rd_o && (avail < want) &&
                (rd_left_r != '0);
    srch_go_o = (state_r == ST_FILL) && !settle && !rd_o && !fill_o &&
                (look_cnt_i == want);
    tok_take  = (state_r == ST_SEARCH) && srch_done_i;
    last_tok  = (con_left_r == lz77_pkg::cnt_t'(srch_len_i));
  end

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      ST_IDLE:   if (start_ok) state_nxt = ST_FILL;
      ST_FILL:   if (srch_go_o) state_nxt = ST_SEARCH;
      ST_SEARCH: if (tok_take) state_nxt = last_tok ? ST_IDLE : ST_FILL;
      default:   state_nxt = ST_IDLE;
    endcase
  end

  //--------------------------------------------------------------------
  // state, counters and strobes
  //--------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_r    <= ST_IDLE;
      rd_left_r  <= '0;
      con_left_r <= '0;
      rd_o       <= 1'b0;
      fill_o     <= 1'b0;
      clr_o      <= 1'b0;
      adv_o      <= 1'b0;
      tok_val_o  <= 1'b0;
      tok_lst_o  <= 1'b0;
      done_o     <= 1'b0;
    end else begin
      state_r   <= state_nxt;
      rd_o      <= rd_req;
      fill_o    <= rd_o;
      clr_o     <= start_ok;
      adv_o     <= tok_take;
      tok_val_o <= tok_take;
      tok_lst_o <= tok_take && last_tok;
      done_o    <= tok_val_o && tok_lst_o;
      if (start_ok) begin
        rd_left_r  <= len_i;
        con_left_r <= len_i;
      end else begin
        if (rd_req) rd_left_r <= rd_left_r - 1'b1;
        if (tok_take) con_left_r <= con_left_r - srch_len_i;
      end
    end
  end

  // token payload and advance length
  always_ff @(posedge clk) begin
    if (tok_take) begin
      adv_len_o <= srch_len_i;
      tok_lit_o <= srch_lit_i;
      tok_pay_o <= srch_pay_i;
    end
  end

  a_no_rd_in_search: assert property (@(posedge clk) disable iff (!rstn)
    (state_r == ST_SEARCH) |-> !rd_o)
    else $error("read issued during search");

  a_adv_in_look: assert property (@(posedge clk) disable iff (!rstn)
    adv_o |-> (adv_len_o <= look_cnt_i))
    else $error("advance beyond lookahead");

endmodule

/* logic/lz77_top.sv */
//----------------------------------------------------------------------
// lz77 compressor top level
// one job per start_i pulse, len_i bytes, zero-length jobs are ignored
// the byte source must answer each rd_o on rd_dat_i one cycle later
// no back-pressure on the token output
// MIN_LEN must lie between 2 and lz77_pkg::MAX_LEN
//----------------------------------------------------------------------

`timescale 1ns/1ps

module lz77_top #(
  parameter int MIN_LEN = 3
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   start_i,
  input  lz77_pkg::cnt_t         len_i,
  output logic                   rd_o,
  input  lz77_pkg::byte_t        rd_dat_i,
  output logic                   tok_val_o,
  output logic                   tok_lit_o,
  output logic                   tok_lst_o,
  output logic                   done_o,
  output lz77_pkg::tok_payload_u tok_pay_o
);

  // ctrl to window
  logic           fill;
  logic           clr;
  logic           adv;
  lz77_pkg::len_t adv_len;

  // window state
  lz77_pkg::byte_t [lz77_pkg::WIN_SIZE-1:0] hist;
  lz77_pkg::byte_t [lz77_pkg::MAX_LEN-1:0]  look;
  lz77_pkg::dst_t                           hist_cnt;
  lz77_pkg::len_t                           look_cnt;

  // search handshake
  logic                   srch_go;
  logic                   srch_done;
  logic                   srch_lit;
  lz77_pkg::len_t         srch_len;
  lz77_pkg::tok_payload_u srch_pay;

  lz77_ctrl i_ctrl (
    .clk         (clk),
    .rstn        (rstn),
    .start_i     (start_i),
    .len_i       (len_i),
    .look_cnt_i  (look_cnt),
    .srch_done_i (srch_done),
    .srch_lit_i  (srch_lit),
    .srch_len_i  (srch_len),
    .srch_pay_i  (srch_pay),
    .rd_o        (rd_o),
    .fill_o      (fill),
    .clr_o       (clr),
    .adv_o       (adv),
    .srch_go_o   (srch_go),
    .adv_len_o   (adv_len),
    .tok_val_o   (tok_val_o),
    .tok_lit_o   (tok_lit_o),
    .tok_lst_o   (tok_lst_o),
    .done_o      (done_o),
    .tok_pay_o   (tok_pay_o)
  );

  lz77_window i_window (
    .clk        (clk),
    .rstn       (rstn),
    .clr_i      (clr),
    .fill_i     (fill),
    .adv_i      (adv),
    .fill_dat_i (rd_dat_i),
    .adv_len_i  (adv_len),
    .hist_o     (hist),
    .look_o     (look),
    .hist_cnt_o (hist_cnt),
    .look_cnt_o (look_cnt)
  );

  lz77_match #(
    .MIN_LEN (MIN_LEN)
  ) i_match (
    .clk        (clk),
    .rstn       (rstn),
    .go_i       (srch_go),
    .hist_i     (hist),
    .look_i     (look),
    .hist_cnt_i (hist_cnt),
    .look_cnt_i (look_cnt),
    .done_o     (srch_done),
    .lit_o      (srch_lit),
    .len_o      (srch_len),
    .pay_o      (srch_pay)
  );

endmodule

/* dv/lz77_tb.sv */
//----------------------------------------------------------------------
// testbench for the lz77 compressor top level
// runs from the project root, records come from dv/lz77_patterns.txt
// expected tokens in that file assume MIN_LEN 3, WIN_SIZE 16, MAX_LEN 8
// at most 64 stream bytes and 64 tokens per record
//----------------------------------------------------------------------

`timescale 1ns/1ps

module lz77_tb;

  localparam int          CLK_HALF  = 50;
  localparam int          DRV_DLY   = 1;
  localparam int          RST_CYC   = 4;
  localparam int          MAX_ITEMS = 64;
  localparam int          TO_FACTOR = 3 + lz77_pkg::MAX_LEN + 2;
  localparam logic [31:0] SEED      = 32'h104c98b9;

  logic                   clk;
  logic                   rstn;
  logic                   start;
  lz77_pkg::cnt_t         job_len;
  logic                   rd;
  lz77_pkg::byte_t        rd_dat;
  logic                   tok_val;
  logic                   tok_lit;
  logic                   tok_lst;
  logic                   done;
  lz77_pkg::tok_payload_u tok_pay;

  // current record
  reg [8*16-1:0]   name;
  int              n_bytes;
  int              n_toks;
  lz77_pkg::byte_t src      [MAX_ITEMS];
  bit              exp_lit  [MAX_ITEMS];
  lz77_pkg::byte_t exp_byte [MAX_ITEMS];
  lz77_pkg::len_t  exp_len  [MAX_ITEMS];
  lz77_pkg::dst_t  exp_dst  [MAX_ITEMS];

  int fd;
  int test_err;
  int n_run;
  int n_bad;
  bit setup_bad;
  bit got;
  int cycles = 0;
  int limit  = RST_CYC + 10;

  lz77_top #(
    .MIN_LEN (3)
  ) i_dut (
    .clk       (clk),
    .rstn      (rstn),
    .start_i   (start),
    .len_i     (job_len),
    .rd_o      (rd),
    .rd_dat_i  (rd_dat),
    .tok_val_o (tok_val),
    .tok_lit_o (tok_lit),
    .tok_lst_o (tok_lst),
    .done_o    (done),
    .tok_pay_o (tok_pay)
  );

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  // run limit grows with every record that is loaded
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("timeout, no end of job after %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #DRV_DLY;
  endtask

  //--------------------------------------------------------------------
  // compare tasks
  //--------------------------------------------------------------------
  task automatic check_kind(input int idx, input logic exp, input logic act,
                            output bit same);
    same = (act === exp);
    if (!same) begin
      $display("FAILED %0s token %0d: expected kind %0s, actual kind %0s",
               name, idx, exp ? "L" : "M", act ? "L" : "M");
      test_err++;
    end
  endtask

  task automatic check_lit(input int idx, input lz77_pkg::byte_t exp,
                           input lz77_pkg::byte_t act);
    if (act !== exp) begin
      $display("FAILED %0s token %0d: expected L %02h, actual L %02h", name, idx, exp, act);
      test_err++;
    end
  endtask

  task automatic check_match(input int idx, input lz77_pkg::len_t len,
                             input lz77_pkg::dst_t dst, input lz77_pkg::tok_payload_u act);
    if (act.mat.len !== len || act.mat.dst !== dst) begin
      $display("FAILED %0s token %0d: expected M %0d %0d, actual M %0d %0d",
               name, idx, len, dst, act.mat.len, act.mat.dst);
      test_err++;
    end
  endtask

  //--------------------------------------------------------------------
  // pattern reader
  //--------------------------------------------------------------------
  task automatic load_record(output bit ok);
    reg [8*16-1:0]  word;
    reg [8*128-1:0] line;
    int             r;
    int             a;
    int             b;
    ok     = 1'b0;
    n_toks = 0;
    r = $fscanf(fd, "%s", word);
    // comment lines start with a lone #
    while (r == 1 && word == "#") begin
      r = $fgets(line, fd);
      r = $fscanf(fd, "%s", word);
    end
    if (r == 1 && word == "T") begin
      r = $fscanf(fd, "%s %d", name, n_bytes);
      r = $fscanf(fd, "%s", word);
      for (int i = 0; i < n_bytes; i++) begin
        r = $fscanf(fd, "%h", a);
        src[i] = a;
      end
      r = $fscanf(fd, "%s", word);
      while (r == 1 && word != "E") begin
        exp_lit[n_toks] = (word == "L");
        if (word == "L") begin
          r = $fscanf(fd, "%h", a);
          exp_byte[n_toks] = a;
        end else begin
          r = $fscanf(fd, "%d %d", a, b);
          exp_len[n_toks] = a;
          exp_dst[n_toks] = b;
        end
        n_toks++;
        r = $fscanf(fd, "%s", word);
      end
      ok = 1'b1;
    end
  endtask

  //--------------------------------------------------------------------
  // one job, byte source model and token checks
  //--------------------------------------------------------------------
  task automatic run_job();
    int gap;
    int nxt;
    int n_got;
    bit lst_seen;
    bit fin;
    bit kind_ok;
    gap      = $urandom % 6;
    nxt      = 0;
    n_got    = 0;
    lst_seen = 1'b0;
    fin      = 1'b0;
    repeat (gap) next_cycle();
    start   = 1'b1;
    job_len = n_bytes;
    next_cycle();
    start = 1'b0;
    while (!fin) begin
      // byte held on rd_dat through the following cycle
      if (rd) begin
        if (nxt < n_bytes) begin
          rd_dat = src[nxt];
        end else begin
          $display("%0s: read request beyond the %0d stream bytes", name, n_bytes);
          test_err++;
        end
        nxt++;
      end
      if (lst_seen) begin
        if (done !== 1'b1) begin
          $display("%0s: done_o missing one cycle after the last token", name);
          test_err++;
        end
        fin = 1'b1;
      end else if (done) begin
        $display("%0s: done_o pulsed before the last token", name);
        test_err++;
      end
      if (tok_val && !fin) begin
        if (n_got >= n_toks) begin
          $display("%0s: extra token %0d beyond the %0d expected", name, n_got, n_toks);
          test_err++;
        end else begin
          check_kind(n_got, exp_lit[n_got], tok_lit, kind_ok);
          if (kind_ok) begin
            if (exp_lit[n_got]) begin
              check_lit(n_got, exp_byte[n_got], tok_pay.lit.dat);
            end else begin
              check_match(n_got, exp_len[n_got], exp_dst[n_got], tok_pay);
            end
          end
        end
        n_got++;
        if (tok_lst) begin
          lst_seen = 1'b1;
          if (n_got < n_toks) begin
            $display("%0s: job ended after %0d of %0d tokens", name, n_got, n_toks);
            test_err++;
          end
        end else if (n_got == n_toks) begin
          $display("%0s: tok_lst_o missing on the last expected token", name);
          test_err++;
        end
      end
      if (!fin) next_cycle();
    end
  endtask

  initial begin
    rstn      = 1'b0;
    start     = 1'b0;
    job_len   = '0;
    rd_dat    = '0;
    n_run     = 0;
    n_bad     = 0;
    setup_bad = 1'b0;
    void'($urandom(SEED));
    repeat (RST_CYC) @(posedge clk);
    #DRV_DLY;
    rstn = 1'b1;
    fd = $fopen("dv/lz77_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open the pattern file dv/lz77_patterns.txt");
      setup_bad = 1'b1;
    end else begin
      load_record(got);
      while (got) begin
        limit    = limit + n_bytes * TO_FACTOR + 20;
        test_err = 0;
        run_job();
        n_run++;
        if (test_err == 0) begin
          $display("ok   %0s, %0d tokens", name, n_toks);
        end else begin
          $display("bad  %0s, %0d errors", name, test_err);
          n_bad++;
        end
        load_record(got);
      end
      $fclose(fd);
      if (n_run == 0) begin
        $display("no test records in the pattern file");
        setup_bad = 1'b1;
      end
    end
    $display("tests run %0d, passed %0d, with errors %0d", n_run, n_run - n_bad, n_bad);
    if (n_bad == 0 && !setup_bad) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* lz77_top.f */
logic/lz77_pkg.sv
logic/lz77_window.sv
logic/lz77_match.sv
logic/lz77_ctrl.sv
logic/lz77_top.sv
dv/lz77_tb.sv

/* dv/lz77_patterns.txt */
# record: T <name> <byte count>, B <bytes in hex>, then tokens up to E
# token: L <byte in hex> is a literal, M <length> <distance> is a match
T distinct 6
B 41 42 43 44 45 46
L 41 L 42 L 43 L 44 L 45 L 46 E
T repeat 10
B 61 61 61 61 61 61 61 61 61 61
L 61 L 61 L 61 M 3 3 M 4 4 E
T tie 11
B 61 62 63 78 61 62 63 79 61 62 63
L 61 L 62 L 63 L 78 M 3 4 L 79 M 3 4 E
T longer 13
B 61 62 63 64 78 61 62 63 79 61 62 63 64
L 61 L 62 L 63 L 64 L 78 M 3 5 L 79 M 4 9 E
T caps 21
B 01 02 03 04 05 06 07 08 09 0a 01 02 03 04 05 06 07 08 09 0a 01
L 01 L 02 L 03 L 04 L 05 L 06 L 07 L 08 L 09 L 0a
M 8 10 M 3 10 E
T again_1 9
B 61 62 63 61 62 63 61 62 63
L 61 L 62 L 63 M 3 3 M 3 3 E
T again_2 9
B 61 62 63 61 62 63 61 62 63
L 61 L 62 L 63 M 3 3 M 3 3 E
